// ==== fpFormatPkg.sv ====
//////////////////////////////
// fp format definitions
// widths and field layout of the 64-bit fp result word,
// double view and NaN-boxed single view
//////////////////////////////
`default_nettype none

package fpFormatPkg;

  localparam int FLEN  = 64;          // fp result word
  localparam int XLEN  = 64;          // integer result word
  localparam int wordW = 32;          // 32-bit integer conversions

  // double precision
  localparam int dNe = 11;
  localparam int dNf = 52;

  // single precision
  localparam int sNe  = 8;
  localparam int sNf  = 23;
  localparam int sLen = 1 + sNe + sNf;  // 32
  localparam int boxW = FLEN - sLen;    // upper ones of the NaN box

  // output format select
  typedef enum logic {
    fmtSingle = 1'b0,
    fmtDouble = 1'b1
  } fmtT;

  //////////////////////////////
  // result word views
  //////////////////////////////

  typedef struct packed {
    logic           sign;
    logic [dNe-1:0] exp;
    logic [dNf-1:0] frac;
  } dblFieldsT;

  typedef struct packed {
    logic [boxW-1:0] box;   // all ones for a legal boxed single
    logic            sign;
    logic [sNe-1:0]  exp;
    logic [sNf-1:0]  frac;
  } sglFieldsT;

  // same 64 bits, read as double or as boxed single
  typedef union packed {
    dblFieldsT d;
    sglFieldsT s;
  } fpWordU;

endpackage

`default_nettype wire

// ==== fpPostProc.f ====
fpFormatPkg.sv
postProcPkg.sv
postProcIf.sv
specialCaseSelect.sv
resultFifo.sv
resultEncode.sv
fpPostProc.sv
tbClockGen.sv
tbFpPostProc.sv

// ==== fpPostProc.sv ====
//////////////////////////////
// fp post-processing top
// classify, queue, encode
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpPostProc
  import fpFormatPkg::*;
  import postProcPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  output logic            inReady,
  input  opKindT          opKind,
  input  fmtT             fmt,
  input  frmT             frm,
  input  logic            rs,
  input  logic [dNe-1:0]  re,
  input  logic [dNf-1:0]  rf,
  input  logic            fullReNeg,
  input  logic            plus1,
  input  logic            invalid,
  input  logic            overflow,
  input  logic            divByZero,
  input  logic            nanIn,
  input  logic            infIn,
  input  logic            xInf,
  input  logic            yInf,
  input  logic            xZero,
  input  logic            xs,
  input  logic            intZero,
  input  logic            int64,
  input  logic            isSigned,
  input  logic            cvtResUf,
  input  logic            cvtCeNeg,
  input  logic            intInvalid,
  input  logic [XLEN-1:0] cvtNegRes,
  output logic            outValid,
  input  logic            outReady,
  output fpWordU          fpRes,
  output logic [XLEN-1:0] intRes
);

  postProcIf prodToFifo (.clk(clk));  // classifier to queue
  postProcIf fifoToCons (.clk(clk));  // queue to encoder

  specialCaseSelect i_specialCaseSelect (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
    .opKind(opKind), .fmt(fmt), .frm(frm),
    .rs(rs), .re(re), .rf(rf), .fullReNeg(fullReNeg), .plus1(plus1),
    .invalid(invalid), .overflow(overflow), .divByZero(divByZero),
    .nanIn(nanIn), .infIn(infIn), .xInf(xInf), .yInf(yInf), .xZero(xZero),
    .xs(xs), .intZero(intZero), .int64(int64), .isSigned(isSigned),
    .cvtResUf(cvtResUf), .cvtCeNeg(cvtCeNeg), .intInvalid(intInvalid),
    .cvtNegRes(cvtNegRes),
    .outStream(prodToFifo.src)
  );

  resultFifo i_resultFifo (
    .clk(clk), .rstN(rstN),
    .inStream(prodToFifo.dst),
    .outStream(fifoToCons.src)
  );

  resultEncode i_resultEncode (
    .clk(clk), .rstN(rstN),
    .inStream(fifoToCons.dst),
    .outValid(outValid), .outReady(outReady),
    .fpRes(fpRes), .intRes(intRes)
  );

endmodule

`default_nettype wire

// ==== postProcIf.sv ====
//////////////////////////////
// result stream interface
// valid/ready handshake carrying one queued item
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface postProcIf
  import postProcPkg::*;
(
  input logic clk
);

  logic         valid;  // item on the bus
  logic         ready;  // sink takes it this edge
  postProcItemT item;   // held stable while valid and not ready

  // sending side
  modport src (
    input  clk,
    input  ready,
    output valid,
    output item
  );

  // receiving side
  modport dst (
    input  clk,
    input  valid,
    input  item,
    output ready
  );

endinterface

`default_nettype wire

// ==== postProcPkg.sv ====
//////////////////////////////
// post-processing types
// operation kinds, result categories and the item that
// travels between the pipeline stages
//////////////////////////////
`default_nettype none

package postProcPkg;

  import fpFormatPkg::*;

  // kind of operation that produced the rounded result
  typedef enum logic [1:0] {
    opArith    = 2'd0,
    opDiv      = 2'd1,
    opCvtToFp  = 2'd2,
    opCvtToInt = 2'd3
  } opKindT;

  typedef logic [2:0] frmT;  // rounding mode, RISC-V encoding

  // floating result category
  typedef enum logic [2:0] {
    catNormal = 3'd0,
    catNaN    = 3'd1,  // canonical quiet NaN
    catOfInf  = 3'd2,  // overflow to infinity
    catOfMax  = 3'd3,  // overflow to max finite
    catUnder  = 3'd4   // killed result, signed zero
  } fpCatT;

  // integer result category
  typedef enum logic [1:0] {
    intNormal   = 2'd0,
    intOverflow = 2'd1,
    intUnder    = 2'd2
  } intCatT;

  //////////////////////////////
  // queued item
  //////////////////////////////

  typedef struct packed {
    fpCatT           fpCat;
    intCatT          intCat;
    fmtT             fmt;
    logic            rs;         // result sign
    logic [dNe-1:0]  re;         // rounded exponent
    logic [dNf-1:0]  rf;         // rounded fraction
    logic            ufLsb;      // lsb of an underflowed result
    logic            xs;         // sign of x
    logic            nanIn;      // picks the positive overflow entry
    logic            isSigned;
    logic            int64;
    logic            plus1;
    logic [XLEN-1:0] cvtNegRes;  // integer result, negated if needed
  } postProcItemT;

endpackage

`default_nettype wire

// ==== resultEncode.sv ====
//////////////////////////////
// result encode
// builds the final fp and integer result words from the
// queued item and holds them in the output register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module resultEncode
  import fpFormatPkg::*;
  import postProcPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  postProcIf.dst          inStream,
  output logic            outValid,
  input  logic            outReady,
  output fpWordU          fpRes,
  output logic [XLEN-1:0] intRes
);

  postProcItemT    it;
  fpWordU          fpNext;
  logic [XLEN-1:0] intNext;
  logic [XLEN-1:0] ofInt;    // overflow entry of the RISC-V table
  logic            negIn;
  logic            load;

  assign it = inStream.item;

  //////////////////////////////
  // fp result word
  //////////////////////////////

  always_comb begin
    fpNext = '0;
    if (it.fmt == fmtDouble) begin
      unique case (it.fpCat)
        catNaN: begin
          fpNext.d.exp  = '1;
          fpNext.d.frac = {1'b1, {(dNf-1){1'b0}}};  // quiet bit only
        end
        catOfInf: begin
          fpNext.d.sign = it.rs;
          fpNext.d.exp  = '1;
        end
        catOfMax: begin
          fpNext.d.sign = it.rs;
          fpNext.d.exp  = {{(dNe-1){1'b1}}, 1'b0};
          fpNext.d.frac = '1;
        end
        catUnder: begin
          fpNext.d.sign = it.rs;
          fpNext.d.frac = {{(dNf-1){1'b0}}, it.ufLsb};
        end
        default: begin  // normal, passed through
          fpNext.d.sign = it.rs;
          fpNext.d.exp  = it.re;
          fpNext.d.frac = it.rf;
        end
      endcase
    end else begin
      fpNext.s.box = '1;  // NaN box
      unique case (it.fpCat)
        catNaN: begin
          fpNext.s.exp  = '1;
          fpNext.s.frac = {1'b1, {(sNf-1){1'b0}}};
        end
        catOfInf: begin
          fpNext.s.sign = it.rs;
          fpNext.s.exp  = '1;
        end
        catOfMax: begin
          fpNext.s.sign = it.rs;
          fpNext.s.exp  = {{(sNe-1){1'b1}}, 1'b0};
          fpNext.s.frac = '1;
        end
        catUnder: begin
          fpNext.s.sign = it.rs;
          fpNext.s.frac = {{(sNf-1){1'b0}}, it.ufLsb};
        end
        default: begin
          fpNext.s.sign = it.rs;
          fpNext.s.exp  = it.re[sNe-1:0];       // low bits of exponent
          fpNext.s.frac = it.rf[dNf-1 -: sNf];  // top of fraction
        end
      endcase
    end
  end

  //////////////////////////////
  // integer result word
  //////////////////////////////

  assign negIn = it.xs & ~it.nanIn;  // NaN counts as positive

  always_comb begin
    if (it.isSigned) begin
      if (negIn) ofInt = it.int64 ? {1'b1, {(XLEN-1){1'b0}}}
                                  : {{(XLEN-wordW+1){1'b1}}, {(wordW-1){1'b0}}};
      else       ofInt = it.int64 ? {1'b0, {(XLEN-1){1'b1}}}
                                  : {{(XLEN-wordW+1){1'b0}}, {(wordW-1){1'b1}}};
    end else begin
      ofInt = negIn ? '0 : '1;  // unsigned clamps to 0 or all ones
    end
  end

  always_comb begin
    unique case (it.intCat)
      intOverflow: intNext = ofInt;
      intUnder: begin
        if (it.xs & it.isSigned & it.plus1) intNext = '1;  // rounds to -1
        else                                intNext = {{(XLEN-1){1'b0}}, it.plus1};
      end
      default: begin
        if (it.int64) intNext = it.cvtNegRes;
        else          intNext = {{(XLEN-wordW){it.cvtNegRes[wordW-1]}}, it.cvtNegRes[wordW-1:0]};
      end
    endcase
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  assign inStream.ready = ~outValid | outReady;
  assign load           = inStream.valid & inStream.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (inStream.ready) begin
      outValid <= inStream.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      fpRes  <= fpNext;
      intRes <= intNext;
    end
  end

endmodule

`default_nettype wire

// ==== resultFifo.sv ====
//////////////////////////////
// result queue
// two-entry FIFO between classification and encoding
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module resultFifo
  import postProcPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  postProcIf.dst inStream,
  postProcIf.src outStream
);

  postProcItemT mem [0:1];  // storage
  logic         wrPtr;
  logic         rdPtr;
  logic [1:0]   count;      // occupancy 0..2
  logic         push;
  logic         pop;

  // full only when both entries hold items
  assign inStream.ready  = (count != 2'd2);
  assign outStream.valid = (count != 2'd0);
  assign outStream.item  = mem[rdPtr];  // head of queue

  assign push = inStream.valid & inStream.ready;
  assign pop  = outStream.valid & outStream.ready;

  //////////////////////////////
  // pointers and count
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) begin
        wrPtr <= ~wrPtr;
      end
      if (pop) begin
        rdPtr <= ~rdPtr;
      end
      unique case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inStream.item;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the fpPostProc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tbFpPostProc \
  -f fpPostProc.f \
  -o simFpPostProc

./obj_dir/simFpPostProc > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
exit 0

// ==== specialCaseSelect.sv ====
//////////////////////////////
// special case select
// classifies the rounded result into fp and integer
// categories, one register stage
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module specialCaseSelect
  import fpFormatPkg::*;
  import postProcPkg::*;
(
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  output logic            inReady,
  input  opKindT          opKind,
  input  fmtT             fmt,
  input  frmT             frm,
  input  logic            rs,          // result sign
  input  logic [dNe-1:0]  re,          // result exponent
  input  logic [dNf-1:0]  rf,          // result fraction
  input  logic            fullReNeg,   // sign of the full exponent
  input  logic            plus1,       // rounding adds one
  input  logic            invalid,
  input  logic            overflow,
  input  logic            divByZero,
  input  logic            nanIn,       // some input is NaN
  input  logic            infIn,       // some input is infinite
  input  logic            xInf,
  input  logic            yInf,
  input  logic            xZero,
  input  logic            xs,          // sign of x
  input  logic            intZero,     // integer input is zero
  input  logic            int64,
  input  logic            isSigned,
  input  logic            cvtResUf,    // conversion underflows
  input  logic            cvtCeNeg,    // conversion exponent negative
  input  logic            intInvalid,
  input  logic [XLEN-1:0] cvtNegRes,
  postProcIf.src          outStream
);

  logic         divOp;
  logic         cvtOp;
  logic         intToFp;
  logic         ofResMax;
  logic         selOfRes;
  logic         killRes;
  logic         load;
  postProcItemT itemNext;

  assign divOp   = (opKind == opDiv);
  assign intToFp = (opKind == opCvtToFp);
  assign cvtOp   = intToFp | (opKind == opCvtToInt);

  //////////////////////////////
  // floating category
  //////////////////////////////

  // max finite for rtz, and for rdn/rup toward the finite side
  assign ofResMax = (~infIn | intToFp) & ~divByZero &
                    ((frm[1:0] == 2'b01) |
                     ((frm[1:0] == 2'b10) & ~rs) |
                     ((frm[1:0] == 2'b11) & rs));

  assign selOfRes = overflow | divByZero | (infIn & ~(yInf & divOp));  // x/inf is not overflow

  // zero the result; only look at the integer or fp input actually used
  assign killRes = cvtOp ? (cvtResUf | (xZero & ~intToFp) | (intZero & intToFp))
                         : (fullReNeg | (((yInf & ~xInf) | xZero) & divOp));

  always_comb begin
    itemNext = '0;
    if (nanIn | invalid) itemNext.fpCat = catNaN;
    else if (selOfRes)   itemNext.fpCat = ofResMax ? catOfMax : catOfInf;
    else if (killRes)    itemNext.fpCat = catUnder;
    else                 itemNext.fpCat = catNormal;

    // integer side, invalid beats underflow
    if (intInvalid)    itemNext.intCat = intOverflow;
    else if (cvtCeNeg) itemNext.intCat = intUnder;
    else               itemNext.intCat = intNormal;

    itemNext.fmt       = fmt;
    itemNext.rs        = rs;
    itemNext.re        = re;
    itemNext.rf        = rf;
    itemNext.ufLsb     = plus1 & frm[1] & ~(divOp & yInf);  // x/inf is exact zero
    itemNext.xs        = xs;
    itemNext.nanIn     = nanIn;
    itemNext.isSigned  = isSigned;
    itemNext.int64     = int64;
    itemNext.plus1     = plus1;
    itemNext.cvtNegRes = cvtNegRes;
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  assign inReady = ~outStream.valid | outStream.ready;  // empty or draining
  assign load    = inValid & inReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outStream.valid <= 1'b0;
    end else if (inReady) begin
      outStream.valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      outStream.item <= itemNext;  // classified result
    end
  end

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
//////////////////////////////
// testbench clock and reset
// 20 ns clock, reset low for 10 cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // half period
  end

  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;  // sync release on an edge
  end

endmodule

`default_nettype wire

// ==== tbFpPostProc.sv ====
//////////////////////////////
// fp post-processing testbench
// directed tests on the stream top level, a model of the
// result rules and an in-order scoreboard on the output
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbFpPostProc
  import fpFormatPkg::*;
  import postProcPkg::*;
();

  // input flags of one result
  typedef struct packed {
    logic fullReNeg, plus1, invalid, overflow, divByZero, nanIn, infIn;
    logic xInf, yInf, xZero, xs, intZero;
    logic int64, isSigned, cvtResUf, cvtCeNeg, intInvalid;
  } flagsT;

  typedef struct packed {
    opKindT          opKind;
    fmtT             fmt;
    frmT             frm;
    logic            rs;
    logic [dNe-1:0]  re;
    logic [dNf-1:0]  rf;
    flagsT           f;
    logic [XLEN-1:0] cvtNegRes;
  } stimT;

  localparam int flagW      = $bits(flagsT);
  localparam int totalItems = 81;                    // 4+4+12+6+15+40
  localparam int limitCycles = totalItems * 20 + 200;

  logic            clk;
  logic            rstN;
  logic            inValid;
  logic            inReady;
  stimT            drv;             // everything on the input side
  logic            outValid;
  logic            outReady;
  fpWordU          fpRes;
  logic [XLEN-1:0] intRes;

  fpWordU          expFpQ [$];      // expected results in order
  logic [XLEN-1:0] expIntQ [$];
  bit              bpOn;            // random back-pressure enable
  int              errors;
  int              idleErrors;
  int              checks;
  int              errBefore;
  int              testsRun;
  int              testsFailed;
  string           curTest;

  tbClockGen i_tbClockGen (.clk(clk), .rstN(rstN));

  fpPostProc i_fpPostProc (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
    .opKind(drv.opKind), .fmt(drv.fmt), .frm(drv.frm),
    .rs(drv.rs), .re(drv.re), .rf(drv.rf),
    .fullReNeg(drv.f.fullReNeg), .plus1(drv.f.plus1), .invalid(drv.f.invalid),
    .overflow(drv.f.overflow), .divByZero(drv.f.divByZero), .nanIn(drv.f.nanIn),
    .infIn(drv.f.infIn), .xInf(drv.f.xInf), .yInf(drv.f.yInf), .xZero(drv.f.xZero),
    .xs(drv.f.xs), .intZero(drv.f.intZero), .int64(drv.f.int64),
    .isSigned(drv.f.isSigned), .cvtResUf(drv.f.cvtResUf), .cvtCeNeg(drv.f.cvtCeNeg),
    .intInvalid(drv.f.intInvalid), .cvtNegRes(drv.cvtNegRes),
    .outValid(outValid), .outReady(outReady), .fpRes(fpRes), .intRes(intRes)
  );

  //////////////////////////////
  // expected results
  //////////////////////////////

  function automatic fpWordU modelFp(input stimT s);
    logic   isDiv, toFp, isCvt, nan, ovf, toMax, kill, lsb;
    fpWordU w;
    isDiv = (s.opKind == opDiv);
    toFp  = (s.opKind == opCvtToFp);
    isCvt = toFp || (s.opKind == opCvtToInt);
    nan   = s.f.nanIn || s.f.invalid;
    ovf   = s.f.overflow || s.f.divByZero || (s.f.infIn && !(isDiv && s.f.yInf));
    // rtz, rdn when positive, rup when negative
    toMax = (!s.f.infIn || toFp) && !s.f.divByZero &&
            ((s.frm[1:0] == 2'd1) || (s.frm[1:0] == 2'd2 && !s.rs) ||
             (s.frm[1:0] == 2'd3 && s.rs));
    if (isCvt) kill = s.f.cvtResUf || (s.f.xZero && !toFp) || (s.f.intZero && toFp);
    else       kill = s.f.fullReNeg || (isDiv && ((s.f.yInf && !s.f.xInf) || s.f.xZero));
    lsb = s.f.plus1 && s.frm[1] && !(isDiv && s.f.yInf);
    if (s.fmt == fmtDouble) begin
      if (nan)               w = 64'h7ff8_0000_0000_0000;
      else if (ovf && toMax) w = {s.rs, 11'h7fe, {52{1'b1}}};
      else if (ovf)          w = {s.rs, 11'h7ff, 52'd0};
      else if (kill)         w = {s.rs, 62'd0, lsb};
      else                   w = {s.rs, s.re, s.rf};
    end else begin
      if (nan)               w = 64'hffff_ffff_7fc0_0000;  // boxed canonical NaN
      else if (ovf && toMax) w = {32'hffff_ffff, s.rs, 8'hfe, {23{1'b1}}};
      else if (ovf)          w = {32'hffff_ffff, s.rs, 8'hff, 23'd0};
      else if (kill)         w = {32'hffff_ffff, s.rs, 30'd0, lsb};
      else                   w = {32'hffff_ffff, s.rs, s.re[7:0], s.rf[51:29]};
    end
    return w;
  endfunction

  function automatic logic [XLEN-1:0] modelInt(input stimT s);
    logic            neg;
    logic [XLEN-1:0] r;
    neg = s.f.xs && !s.f.nanIn;  // NaN saturates high
    if (s.f.intInvalid) begin
      if (!s.f.isSigned)  r = neg ? 64'd0 : {64{1'b1}};
      else if (s.f.int64) r = neg ? 64'h8000_0000_0000_0000 : 64'h7fff_ffff_ffff_ffff;
      else                r = neg ? 64'hffff_ffff_8000_0000 : 64'h0000_0000_7fff_ffff;
    end else if (s.f.cvtCeNeg) begin
      if (s.f.xs && s.f.isSigned && s.f.plus1) r = {64{1'b1}};
      else                                     r = {63'd0, s.f.plus1};
    end else if (s.f.int64) begin
      r = s.cvtNegRes;
    end else begin
      r = {{32{s.cvtNegRes[31]}}, s.cvtNegRes[31:0]};
    end
    return r;
  endfunction

  //////////////////////////////
  // compare and scoreboard
  //////////////////////////////

  task automatic compareFp(input fpWordU got, input fpWordU want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      if (want.s.box == '1)
        $display("FAIL %0d ns %s %s single got s%b e%h f%h expected %h", $time, curTest,
                 what, got.s.sign, got.s.exp, got.s.frac, want);
      else
        $display("FAIL %0d ns %s %s double got s%b e%h f%h expected %h", $time, curTest,
                 what, got.d.sign, got.d.exp, got.d.frac, want);
    end
  endtask

  task automatic compareInt(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want,
                            input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0d ns %s %s got %h expected %h", $time, curTest, what, got, want);
    end
  endtask

  // a stalled result is checked every cycle until it leaves
  always @(posedge clk) begin
    if (rstN && outValid) begin
      if (expFpQ.size() == 0) begin
        $display("result seen at %0d ns with no item outstanding", $time);
        errors++;
      end else begin
        compareFp(fpRes, expFpQ[0], "fp");
        compareInt(intRes, expIntQ[0], "int");
        if (outReady) begin
          void'(expFpQ.pop_front());
          void'(expIntQ.pop_front());
        end
      end
    end
  end

  // random stalls only while bpOn
  initial begin
    outReady = 1'b1;
    forever begin
      @(posedge clk);
      if (bpOn) outReady <= 1'($urandom);
      else      outReady <= 1'b1;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic stimT baseStim();
    stimT s;
    s           = '0;
    s.opKind    = opArith;
    s.fmt       = fmtDouble;
    s.re        = 11'h400;
    s.rf        = 52'h8_0000_0000_0001;
    s.f.int64   = 1'b1;
    s.cvtNegRes = 64'h0123_4567_89ab_cdef;
    return s;
  endfunction

  function automatic stimT randomStim();
    stimT s;
    s           = baseStim();
    s.opKind    = opKindT'(2'($urandom));
    s.fmt       = fmtT'(1'($urandom));
    s.frm       = 3'($urandom);
    s.rs        = 1'($urandom);
    s.re        = 11'($urandom);
    s.rf        = {20'($urandom), 32'($urandom)};
    s.f         = flagsT'(flagW'($urandom) & flagW'($urandom));  // each flag 1 in 4
    s.cvtNegRes = {32'($urandom), 32'($urandom)};
    return s;
  endfunction

  // caller sits on a rising edge; returns on the edge of the transfer
  task automatic sendItem(input stimT s, input int gap);
    repeat (gap) begin
      inValid <= 1'b0;
      @(posedge clk);
    end
    drv     <= s;
    inValid <= 1'b1;
    expFpQ.push_back(modelFp(s));
    expIntQ.push_back(modelInt(s));
    @(posedge clk);
    while (!inReady) @(posedge clk);
  endtask

  task automatic startTest(input string name);
    curTest   = name;
    errBefore = errors;
  endtask

  task automatic endTest();
    inValid <= 1'b0;
    while (expFpQ.size() != 0) @(posedge clk);  // wait until every result is back
    testsRun++;
    if (errors == errBefore) begin
      $display("test %s: ok", curTest);
    end else begin
      testsFailed++;
      $display("test %s: %0d mismatches", curTest, errors - errBefore);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic testNormal();
    stimT s;
    startTest("normal");
    for (int k = 0; k < 4; k++) begin
      s      = baseStim();
      s.fmt  = fmtT'(k[0]);
      s.rs   = k[1];
      s.re   = 11'h381 + 11'(k);
      s.rf   = 52'ha_5c3f_0e96_1b27 ^ {52{k[1]}};
      sendItem(s, 0);
    end
    endTest();
  endtask

  task automatic testPriority();
    stimT s;
    startTest("priority");
    for (int k = 0; k < 4; k++) begin
      s             = baseStim();
      s.f.nanIn     = k[0];
      s.f.invalid   = ~k[0];
      s.fmt         = fmtT'(k[1]);
      s.opKind      = k[1] ? opDiv : opArith;
      s.f.overflow  = 1'b1;
      s.f.divByZero = k[1];
      s.f.fullReNeg = 1'b1;  // kill also set
      s.f.xZero     = 1'b1;
      s.frm         = 3'd1;
      s.rs          = 1'b1;
      sendItem(s, 0);
    end
    endTest();
  endtask

  task automatic testOverflow();
    stimT s;
    startTest("overflow");
    for (int m = 0; m < 4; m++) begin
      for (int sg = 0; sg < 2; sg++) begin
        s            = baseStim();
        s.f.overflow = 1'b1;
        s.frm        = 3'(m);
        s.rs         = sg[0];
        s.fmt        = fmtT'(m[0] ^ sg[0]);
        sendItem(s, 0);
      end
    end
    for (int sg = 0; sg < 2; sg++) begin  // divide by zero gives infinity even for rtz
      s             = baseStim();
      s.opKind      = opDiv;
      s.f.divByZero = 1'b1;
      s.frm         = 3'd1;
      s.rs          = sg[0];
      sendItem(s, 1);
    end
    for (int k = 0; k < 2; k++) begin  // infinite input gives max only for conversion
      s         = baseStim();
      s.opKind  = k[0] ? opCvtToFp : opArith;
      s.f.infIn = 1'b1;
      s.frm     = 3'd1;
      sendItem(s, 0);
    end
    endTest();
  endtask

  task automatic testUnderflow();
    stimT s;
    startTest("underflow");
    for (int k = 0; k < 6; k++) begin
      s         = baseStim();
      s.f.plus1 = 1'b1;
      s.rs      = k[0];
      case (k)
        0: begin
          s.f.fullReNeg = 1'b1;
          s.frm         = 3'd2;  // lsb set
        end
        1: begin
          s.f.fullReNeg = 1'b1;
          s.frm         = 3'd0;  // rne leaves lsb clear
        end
        2: begin                 // x/inf gives exact zero
          s.opKind  = opDiv;
          s.f.yInf  = 1'b1;
          s.f.infIn = 1'b1;
          s.frm     = 3'd2;
        end
        3: begin
          s.opKind  = opDiv;
          s.f.xZero = 1'b1;
          s.frm     = 3'd3;
          s.fmt     = fmtSingle;
        end
        4: begin
          s.opKind    = opCvtToFp;
          s.f.intZero = 1'b1;
          s.fmt       = fmtSingle;
        end
        default: begin
          s.opKind     = opCvtToInt;
          s.f.cvtResUf = 1'b1;
          s.frm        = 3'd2;
        end
      endcase
      sendItem(s, 0);
    end
    endTest();
  endtask

  task automatic testIntConv();
    stimT s;
    startTest("int convert");
    for (int k = 0; k < 8; k++) begin  // full overflow table
      s              = baseStim();
      s.opKind       = opCvtToInt;
      s.f.intInvalid = 1'b1;
      s.f.invalid    = 1'b1;
      s.f.isSigned   = k[0];
      s.f.xs         = k[1];
      s.f.int64      = k[2];
      sendItem(s, 0);
    end
    s              = baseStim();  // negative NaN clamps high
    s.opKind       = opCvtToInt;
    s.f.intInvalid = 1'b1;
    s.f.nanIn      = 1'b1;
    s.f.xs         = 1'b1;
    s.f.isSigned   = 1'b1;
    sendItem(s, 0);
    for (int k = 0; k < 3; k++) begin
      s            = baseStim();
      s.opKind     = opCvtToInt;
      s.f.cvtCeNeg = 1'b1;
      s.f.xs       = 1'b1;
      s.f.isSigned = (k != 1);
      s.f.plus1    = (k != 2);
      sendItem(s, 0);
    end
    for (int k = 0; k < 3; k++) begin  // 32-bit sign extension then 64-bit pass
      s           = baseStim();
      s.opKind    = opCvtToInt;
      s.f.int64   = (k == 2);
      s.cvtNegRes = (k == 0) ? 64'h0000_0000_8000_1234 : 64'hfedc_ba98_1234_5678;
      sendItem(s, 0);
    end
    endTest();
  endtask

  task automatic testBackPressure();
    startTest("back-pressure");
    bpOn = 1'b1;
    for (int n = 0; n < 40; n++) begin
      sendItem(randomStim(), $urandom_range(0, 3));
    end
    endTest();
    bpOn = 1'b0;
  endtask

  //////////////////////////////
  // main sequence and watchdog
  //////////////////////////////

  initial begin
    void'($urandom(32'h7a2b));
    inValid = 1'b0;
    drv     = '0;
    while (rstN !== 1'b1) @(posedge clk);
    @(posedge clk);
    if (inReady !== 1'b1 || outValid !== 1'b0) begin
      $display("DUT not idle after reset, inReady %b outValid %b", inReady, outValid);
      idleErrors++;
    end
    testNormal();
    testPriority();
    testOverflow();
    testUnderflow();
    testIntConv();
    testBackPressure();
    repeat (5) @(posedge clk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
             checks, errors + idleErrors);
    if (errors + idleErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(limitCycles * 20);
    $display("watchdog expired, results stopped arriving in %s", curTest);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
